/* shipGamePkg.sv */
// ship game shared definitions
`default_nettype none

package shipGamePkg;

    // screen coordinate, playfield is 640 x 480
    typedef logic [9:0] coord_t;

    typedef logic [3:0] velocity_t;     // whole pixels per update

    // one-hot heading, bit k is k * 45 degrees ccw from screen right
    // bit 2 points up (y decreasing), bit 6 points down
    typedef logic [7:0] heading_t;

    typedef logic [27:0] tickCount_t;   // update period in clock cycles
    typedef logic [27:0] cfgData_t;     // config write data
    typedef logic [1:0] cfgAddr_t;      // config register address

    // playfield size
    localparam coord_t screenWidth = 10'd640;
    localparam coord_t screenHeight = 10'd480;

    // reset position, centre of the field
    localparam coord_t startX = 10'd320;
    localparam coord_t startY = 10'd240;

    localparam heading_t defaultHeading = 8'b0000_0001;    // facing right

    // half a second at 50 MHz
    localparam tickCount_t defaultTickPeriod = 28'd25_000_000;

    // speed limits after reset
    localparam velocity_t defaultMaxForward = 4'd2;
    localparam velocity_t defaultMaxBackward = 4'd2;

    // config register map, address 3 unused
    localparam cfgAddr_t cfgAddrPeriod = 2'd0;
    localparam cfgAddr_t cfgAddrMaxForward = 2'd1;
    localparam cfgAddr_t cfgAddrMaxBackward = 2'd2;

endpackage

`default_nettype wire

/* shipConfig.sv */
// ship game config registers
`timescale 1ns/1ps
`default_nettype none

module shipConfig
    import shipGamePkg::*;
(
    input  wire logic       Clk,
    input  wire logic       rstN,
    input  wire logic       cfgWrite,       // one-cycle write strobe
    input  wire cfgAddr_t   cfgAddr,
    input  wire cfgData_t   cfgData,
    output tickCount_t      tickPeriod,     // to moveTick
    output velocity_t       maxForward,     // to shipController
    output velocity_t       maxBackward
);

    // new value shows up the cycle after the strobe
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            tickPeriod <= defaultTickPeriod;
            maxForward <= defaultMaxForward;
            maxBackward <= defaultMaxBackward;
        end
        else if (cfgWrite)
        begin
            case (cfgAddr)
                cfgAddrPeriod:
                begin
                    tickPeriod <= cfgData;                  // full 28 bits
                end
                cfgAddrMaxForward:
                begin
                    maxForward <= cfgData[3:0];             // low nibble only
                end
                cfgAddrMaxBackward:
                begin
                    maxBackward <= cfgData[3:0];
                end
                default:
                begin
                    // address 3, nothing there
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* moveTick.sv */
// update tick generator
`timescale 1ns/1ps
`default_nettype none

module moveTick
    import shipGamePkg::*;
(
    input  wire logic       Clk,
    input  wire logic       rstN,
    input  wire tickCount_t tickPeriod,     // cycles between ticks
    output logic            tick            // one-cycle update pulse
);

    tickCount_t count;          // free-running cycle count
    tickCount_t lastCount;      // count value that fires the tick

    // period 0 treated like period 1
    assign lastCount = (tickPeriod == '0) ? '0 : tickPeriod - 28'd1;

    // at-or-above so a shorter period takes effect at once
    assign tick = (count >= lastCount);

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            count <= '0;
        end
        else if (tick)
        begin
            count <= '0;                // restart the period
        end
        else
        begin
            count <= count + 28'd1;
        end
    end

endmodule

`default_nettype wire

/* shipController.sv */
// ship speed and heading control
`timescale 1ns/1ps
`default_nettype none

module shipController
    import shipGamePkg::*;
(
    input  wire logic       Clk,
    input  wire logic       rstN,
    input  wire logic       tick,           // update pulse from moveTick
    input  wire logic       up,             // button levels
    input  wire logic       down,
    input  wire logic       left,
    input  wire logic       right,
    input  wire velocity_t  maxForward,
    input  wire velocity_t  maxBackward,
    output velocity_t       velocity,
    output heading_t        heading,
    output logic            forward         // 0 while reversing
);

    logic speedUp, speedDown;       // opposite pairs cancel
    logic turnLeft, turnRight;

    heading_t headingCcw;           // one step ccw, index + 1
    heading_t headingCw;            // one step cw, index - 1
    heading_t headingBack;          // turned around 180 degrees

    velocity_t velocityNext;
    heading_t headingNext;
    logic forwardNext;

    assign speedUp = up & ~down;
    assign speedDown = down & ~up;
    assign turnLeft = left & ~right;
    assign turnRight = right & ~left;

    // rotations wrap around the one-hot ring
    assign headingCcw = {heading[6:0], heading[7]};
    assign headingCw = {heading[0], heading[7:1]};
    assign headingBack = {heading[3:0], heading[7:4]};

    always_comb
    begin
        velocityNext = velocity;    // hold by default
        headingNext = heading;
        forwardNext = forward;

        if (velocity == '0)
        begin
            // at rest, turns ignored
            if (speedUp)
            begin
                velocityNext = 4'd1;
                forwardNext = 1'b1;
            end
            else if (speedDown)
            begin
                velocityNext = 4'd1;
                forwardNext = 1'b0;
                headingNext = headingBack;  // heading follows direction of travel
            end
        end
        else if (forward)
        begin
            if (turnLeft)
                headingNext = headingCcw;
            else if (turnRight)
                headingNext = headingCw;

            if (speedUp && (velocity < maxForward))
                velocityNext = velocity + 4'd1;     // accelerate up to limit
            else if (speedDown)
                velocityNext = velocity - 4'd1;     // brake
        end
        else
        begin
            // reversing, steering is mirrored
            if (turnLeft)
                headingNext = headingCw;
            else if (turnRight)
                headingNext = headingCcw;

            if (speedDown && (velocity < maxBackward))
                velocityNext = velocity + 4'd1;
            else if (speedUp)
                velocityNext = velocity - 4'd1;
        end

        // stopped means forward again
        if (velocityNext == '0)
            forwardNext = 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            velocity <= '0;
            heading <= defaultHeading;
            forward <= 1'b1;
        end
        else if (tick)
        begin
            velocity <= velocityNext;   // buttons only count on a tick
            heading <= headingNext;
            forward <= forwardNext;
        end
    end

endmodule

`default_nettype wire

/* shipPosition.sv */
// ship position integrator
`timescale 1ns/1ps
`default_nettype none

module shipPosition
    import shipGamePkg::*;
(
    input  wire logic       Clk,
    input  wire logic       rstN,
    input  wire logic       tick,
    input  wire velocity_t  velocity,       // pre-edge speed
    input  wire heading_t   heading,
    output coord_t          posX,
    output coord_t          posY
);

    logic xInc, xDec;       // unit direction on x
    logic yInc, yDec;       // unit direction on y, inc is down the screen

    // one step along an axis, wraps at both ends
    function automatic coord_t wrapStep(
        input coord_t    pos,
        input velocity_t step,
        input logic      inc,
        input logic      dec,
        input coord_t    limit
    );
        logic [10:0] sum;
        logic [10:0] result;
        begin
            result = {1'b0, pos};
            if (inc)
            begin
                sum = {1'b0, pos} + {7'd0, step};
                result = (sum >= {1'b0, limit}) ? sum - {1'b0, limit} : sum;
            end
            else if (dec)
            begin
                if (pos >= {6'd0, step})
                    result = {1'b0, pos} - {7'd0, step};
                else
                    result = {1'b0, pos} + {1'b0, limit} - {7'd0, step};  // off the low edge
            end
            return result[9:0];
        end
    endfunction

    assign xInc = heading[7] | heading[0] | heading[1];
    assign xDec = heading[3] | heading[4] | heading[5];
    assign yDec = heading[1] | heading[2] | heading[3];    // up
    assign yInc = heading[5] | heading[6] | heading[7];    // down

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            posX <= startX;
            posY <= startY;
        end
        else if (tick)
        begin
            posX <= wrapStep(posX, velocity, xInc, xDec, screenWidth);
            posY <= wrapStep(posY, velocity, yInc, yDec, screenHeight);
        end
    end

endmodule

`default_nettype wire

/* shipGame.sv */
// ship steering top level
`timescale 1ns/1ps
`default_nettype none

module shipGame
    import shipGamePkg::*;
(
    input  wire logic       Clk,
    input  wire logic       rstN,
    input  wire logic       cfgWrite,
    input  wire cfgAddr_t   cfgAddr,
    input  wire cfgData_t   cfgData,
    input  wire logic       up,
    input  wire logic       down,
    input  wire logic       left,
    input  wire logic       right,
    output logic            tick,
    output velocity_t       velocity,
    output heading_t        heading,
    output logic            forward,
    output coord_t          posX,
    output coord_t          posY
);

    tickCount_t tickPeriod;     // config to tick generator
    velocity_t maxForward;      // config to controller
    velocity_t maxBackward;

    shipConfig config_i (
        .Clk(Clk), .rstN(rstN),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .tickPeriod(tickPeriod), .maxForward(maxForward), .maxBackward(maxBackward)
    );

    moveTick tick_i (
        .Clk(Clk), .rstN(rstN), .tickPeriod(tickPeriod), .tick(tick)
    );

    shipController ctrl_i (
        .Clk(Clk), .rstN(rstN), .tick(tick),
        .up(up), .down(down), .left(left), .right(right),
        .maxForward(maxForward), .maxBackward(maxBackward),
        .velocity(velocity), .heading(heading), .forward(forward)
    );

    // lags a speed change by one tick
    shipPosition pos_i (
        .Clk(Clk), .rstN(rstN), .tick(tick),
        .velocity(velocity), .heading(heading),
        .posX(posX), .posY(posY)
    );

endmodule

`default_nettype wire

/* shipGameTb.sv */
// ship steering testbench
`timescale 1ns/1ps
`default_nettype none

module shipGameTb
    import shipGamePkg::*;
();

    localparam int clkPeriod = 8;
    localparam int plannedTicks = 850;      // directed legs plus random phase
    localparam int longestPeriod = 8;
    localparam int timeoutNs = (plannedTicks * longestPeriod + 200) * clkPeriod;

    logic Clk = 1'b0;
    logic rstN, cfgWrite;
    cfgAddr_t cfgAddr;
    cfgData_t cfgData;
    logic up, down, left, right;
    logic tick, forward;
    velocity_t velocity;
    heading_t heading;
    coord_t posX, posY;

    // reference model state
    tickCount_t mCount, mPeriod, mLast;
    velocity_t mMaxF, mMaxB, mVel;
    logic mFwd, sUp, sDn, tL, tR;
    int mDir, mX, mY, vInt, r;
    logic modelReady = 1'b0;
    int valueErrors = 0;
    int tickErrors = 0;
    int tickTotal = 0;

    shipGame dut_i (
        .Clk(Clk), .rstN(rstN),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .up(up), .down(down), .left(left), .right(right),
        .tick(tick), .velocity(velocity), .heading(heading), .forward(forward),
        .posX(posX), .posY(posY)
    );

    always #(clkPeriod / 2) Clk = ~Clk;

    // unit step per heading index, y grows down the screen
    function automatic int dirX(input int d);
        case (d)
            0, 1, 7: return 1;
            3, 4, 5: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int dirY(input int d);
        case (d)
            5, 6, 7: return 1;
            1, 2, 3: return -1;
            default: return 0;
        endcase
    endfunction

    task automatic checkMotion(input velocity_t v, input heading_t h, input logic f);
        if (velocity !== v || heading !== h || forward !== f)
        begin
            valueErrors++;
            $display("Fail %0t: motion vel %0d hdg %b fwd %b, expected vel %0d hdg %b fwd %b",
                $time, velocity, heading, forward, v, h, f);
        end
    endtask

    task automatic checkPosition(input coord_t x, input coord_t y);
        if (posX !== x || posY !== y)
        begin
            valueErrors++;
            $display("Fail %0t: position (%0d, %0d), expected (%0d, %0d)", $time, posX, posY, x, y);
        end
    endtask

    task automatic checkTick(input logic due);
        if (tick !== due)
        begin
            tickErrors++;
            if (due)
                $display("Tick missing at %0t although the period had run out", $time);
            else
                $display("Tick came at %0t before the period had run out", $time);
        end
    endtask

    // model, updated on the same edges as the DUT
    always @(posedge Clk)
    begin
        if (!rstN)
        begin
            mCount = '0;
            mPeriod = defaultTickPeriod;
            mMaxF = defaultMaxForward;
            mMaxB = defaultMaxBackward;
            mVel = '0;
            mDir = 0;                   // facing right
            mFwd = 1'b1;
            mX = startX;
            mY = startY;
            modelReady = 1'b1;
        end
        else if (modelReady)
        begin
            mLast = (mPeriod == '0) ? '0 : mPeriod - 28'd1;
            checkTick(mCount >= mLast);
            if (tick)
            begin
                tickTotal++;
                vInt = int'(mVel);      // pre-edge speed moves the ship
                mX = (mX + dirX(mDir) * vInt + int'(screenWidth)) % int'(screenWidth);
                mY = (mY + dirY(mDir) * vInt + int'(screenHeight)) % int'(screenHeight);
                sUp = up & ~down;
                sDn = down & ~up;
                tL = left & ~right;
                tR = right & ~left;
                if (mVel == '0)
                begin
                    if (sUp)
                    begin
                        mVel = 4'd1;
                        mFwd = 1'b1;
                    end
                    else if (sDn)
                    begin
                        mVel = 4'd1;
                        mFwd = 1'b0;
                        mDir = (mDir + 4) % 8;  // turn around to face travel
                    end
                end
                else if (mFwd)
                begin
                    mDir = tL ? (mDir + 1) % 8 : (tR ? (mDir + 7) % 8 : mDir);
                    if (sUp && mVel < mMaxF)
                        mVel = mVel + 4'd1;
                    else if (sDn)
                        mVel = mVel - 4'd1;
                end
                else
                begin
                    mDir = tL ? (mDir + 7) % 8 : (tR ? (mDir + 1) % 8 : mDir);    // mirrored
                    if (sDn && mVel < mMaxB)
                        mVel = mVel + 4'd1;
                    else if (sUp)
                        mVel = mVel - 4'd1;
                end
                if (mVel == '0)
                    mFwd = 1'b1;
            end
            mCount = (mCount >= mLast) ? '0 : mCount + 28'd1;     // old period rules this edge
            if (cfgWrite)
            begin
                case (cfgAddr)
                    cfgAddrPeriod: mPeriod = cfgData;
                    cfgAddrMaxForward: mMaxF = cfgData[3:0];
                    cfgAddrMaxBackward: mMaxB = cfgData[3:0];
                    default: ;
                endcase
            end
        end
    end

    // outputs settled since the rising edge
    always @(negedge Clk)
    begin
        if (modelReady)
        begin
            checkMotion(mVel, heading_t'(8'd1 << mDir), mFwd);
            checkPosition(coord_t'(mX), coord_t'(mY));
        end
    end

    task automatic writeConfig(input cfgAddr_t a, input cfgData_t d);
        cfgWrite = 1'b1;
        cfgAddr = a;
        cfgData = d;
        @(negedge Clk);
        cfgWrite = 1'b0;
    endtask

    // hold the buttons for n update ticks
    task automatic steer(input logic u, input logic d, input logic l, input logic rt, input int n);
        up = u;
        down = d;
        left = l;
        right = rt;
        repeat (n)
        begin
            @(posedge Clk);
            while (tick !== 1'b1)
                @(posedge Clk);
        end
        @(negedge Clk);
    endtask

    initial
    begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        void'($urandom(42919));
        rstN = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        up = 1'b0;
        down = 1'b0;
        left = 1'b0;
        right = 1'b0;
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        writeConfig(cfgAddrPeriod, 28'd2);  // first tick two cycles later
        steer(1'b0, 1'b0, 1'b1, 1'b0, 2);   // turns at rest ignored
        steer(1'b0, 1'b1, 1'b0, 1'b0, 4);   // reverse from rest, up to the limit
        steer(1'b0, 1'b0, 1'b1, 1'b0, 2);   // mirrored turn
        steer(1'b1, 1'b0, 1'b0, 1'b1, 3);   // brake to zero, forward again
        steer(1'b1, 1'b1, 1'b1, 1'b1, 2);   // both pairs cancel
        writeConfig(cfgAddrMaxForward, 28'd15);
        writeConfig(cfgAddrPeriod, 28'd1);
        for (int leg = 0; leg < 8; leg++)
        begin
            steer(1'b1, 1'b0, 1'b0, 1'b0, 45);  // long enough to wrap
            steer(1'b1, 1'b0, 1'b1, 1'b0, 1);
        end
        // shorten the period below the running count
        writeConfig(cfgAddrPeriod, 28'd8);
        steer(1'b0, 1'b0, 1'b0, 1'b0, 1);
        repeat (5) @(negedge Clk);
        writeConfig(cfgAddrPeriod, 28'd3);
        steer(1'b0, 1'b0, 1'b0, 1'b1, 3);
        for (int i = 0; i < 400; i++)
        begin
            r = $urandom_range(0, 99);
            if (r < 4)
                writeConfig(cfgAddrPeriod, $urandom_range(0, 8));
            else if (r < 7)
                writeConfig(cfgAddrMaxForward, $urandom_range(1, 15));
            else if (r < 10)
                writeConfig(cfgAddrMaxBackward, $urandom_range(1, 15));
            steer($urandom_range(0, 99) < 55, $urandom_range(0, 99) < 30,
                $urandom_range(0, 99) < 25, $urandom_range(0, 99) < 25, 1);
        end
        $display("Ticks %0d, value errors %0d, tick errors %0d", tickTotal, valueErrors, tickErrors);
        if (valueErrors == 0 && tickErrors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* shipGame.f */
shipGamePkg.sv
shipConfig.sv
moveTick.sv
shipController.sv
shipPosition.sv
shipGame.sv
shipGameTb.sv
